/* run_sim.sh */
#!/bin/sh
# compile with Verilator and run one frame of the testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
    --top-module tb_video_composite -f video_composite.f \
    && ./obj_dir/Vtb_video_composite \
    || { echo "simulation failed"; exit 1; }

/* tb/composite_patterns.txt */
// half-line  hcnt  luma  sync_n  chroma class (0 mid, 1 burst swing, 2 not checked)
// all fields hex, rows in frame order, a half-line of ffff ends the list
000 000 00 0 0
000 03a 08 1 0
001 353 00 0 0
001 354 08 1 0
006 2a5 00 0 0
006 2a6 08 1 0
007 5bf 00 0 0
007 5c0 08 1 0
032 0fa 08 1 0
032 190 11 1 0
033 3e8 16 1 0
064 075 00 0 0
064 076 08 1 0
064 08c 08 1 1
064 08d 08 1 1
064 08e 08 1 1
064 08f 08 1 1
064 090 08 1 1
064 091 08 1 1
064 092 08 1 1
064 093 08 1 1
064 0c4 08 1 0
096 1ff 0c 1 2
0fa 1ff 10 1 2
15e 1ff 09 1 2
20d 353 00 0 0
20d 354 08 1 0
213 5bf 00 0 0
214 2a6 08 1 0
23e 190 11 1 0
419 633 08 1 0
ffff 0 0 0 0

/* tb/tb_video_composite.sv */
`timescale 1ns/10ps

module tb_video_composite;

    import video_pkg::*;

    localparam int ROW_WORDS      = 5;
    localparam int MAX_ROWS       = 64;
    // one frame is 1050 half-lines of 794 clocks
    localparam int FRAME_CYCLES   = 833700;
    localparam int TIMEOUT_CYCLES = 900000;

    logic    clk;
    logic    rst;
    luma_t   luma;
    logic    sync_n;
    chroma_t chroma;

    // five hex words per row, see the header of the pattern file
    logic [15:0] pattern_mem [0:MAX_ROWS*ROW_WORDS-1];

    int        num_rows;
    int        row_idx;
    int        timeout_cnt = 0;
    hcount_t   pos_h;
    halfline_t pos_hl;
    logic      seen_above;
    logic      seen_below;

    video_composite UUT (
        .clk    (clk),
        .rst    (rst),
        .luma   (luma),
        .sync_n (sync_n),
        .chroma (chroma)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_luma(input luma_t got, input luma_t exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("** Error at time %0t: %s is %0d, expected %0d",
                                        $time, what, got, exp));
    endtask

    task automatic check_sync(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("** Error at time %0t: %s is %b, expected %b",
                                        $time, what, got, exp));
    endtask

    task automatic check_chroma(input chroma_t got, input chroma_t exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("** Error at time %0t: %s is %0d, expected %0d",
                                        $time, what, got, exp));
    endtask

    function automatic logic [15:0] row_word(input int row, input int field);
        logic [8:0] addr;
        addr = 9'(row * ROW_WORDS + field);
        return pattern_mem[addr];
    endfunction

    // next shown position, from the line and half-line lengths
    task automatic advance_position();
        if (pos_h == H_TOTAL - 1'b1)
            pos_h = '0;
        else
            pos_h = pos_h + 1'b1;
        if (pos_h == '0 || pos_h == H_HALF) begin
            if (pos_hl == V_TOTAL - 1'b1)
                pos_hl = '0;
            else
                pos_hl = pos_hl + 1'b1;
        end
    endtask

    task automatic check_row(input int row);
        string       where;
        logic [15:0] cls;
        where = $sformatf("half-line %0d hcnt %0d", pos_hl, pos_h);
        cls   = row_word(row, 4);
        check_luma(luma, luma_t'(row_word(row, 2)), {"luma at ", where});
        check_sync(sync_n, row_word(row, 3) != 16'h0, {"sync_n at ", where});
        if (cls == 16'h0) begin
            check_chroma(chroma, CHROMA_MID, {"chroma at ", where});
        end else if (cls == 16'h1) begin
            // burst swing is judged over the whole group of rows
            if (chroma > CHROMA_MID)
                seen_above = 1'b1;
            if (chroma < CHROMA_MID)
                seen_below = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        timeout_cnt = timeout_cnt + 1;
        if (timeout_cnt >= TIMEOUT_CYCLES)
            stop_with_failure("timeout: the frame did not complete in time");
    end

    initial begin
        rst        = 1'b1;
        num_rows   = 0;
        row_idx    = 0;
        pos_h      = '0;
        pos_hl     = '0;
        seen_above = 1'b0;
        seen_below = 1'b0;

        $readmemh("tb/composite_patterns.txt", pattern_mem);
        while (num_rows < MAX_ROWS && row_word(num_rows, 0) != 16'hffff)
            num_rows++;
        if (num_rows == MAX_ROWS)
            stop_with_failure("pattern file has no end row or too many rows");

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // reset values still shown before the first counted edge
        @(negedge clk);
        check_luma(luma, LUMA_BLACK, "luma after reset");
        check_sync(sync_n, 1'b1, "sync_n after reset");
        check_chroma(chroma, CHROMA_MID, "chroma after reset");

        // cycle k shows the raster state of count k-1
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            @(negedge clk);
            if (row_idx < num_rows &&
                row_word(row_idx, 0) == 16'(pos_hl) &&
                row_word(row_idx, 1) == 16'(pos_h)) begin
                check_row(row_idx);
                row_idx++;
            end
            advance_position();
        end

        if (row_idx != num_rows)
            stop_with_failure($sformatf("frame ended with %0d pattern rows never reached",
                                        num_rows - row_idx));
        else if (!(seen_above && seen_below))
            stop_with_failure("burst chroma did not swing both above and below mid level");
        else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

/* verilog/ntsc_raster.sv */
`timescale 1ns/10ps
`default_nettype none

module ntsc_raster (
    input  logic             clk,
    input  logic             rst,
    output video_pkg::color_t r,
    output video_pkg::color_t g,
    output video_pkg::color_t b,
    output logic             active,
    output logic             color_burst,
    output logic             sync_in_n
);

    import video_pkg::*;

    hcount_t     hcnt;
    halfline_t   vcnt;
    halfline_t   vcnt_next;
    halfline_t   field_hl_next;
    v_region_t   region;
    v_region_t   region_next;
    logic        field;
    logic [8:0]  field_line_cnt;
    frame_line_t frame_line;

    logic        h_last;
    logic        h_half_end;
    logic        v_last;
    logic        v_field1_last;

    logic        h_hsync_pulse;
    logic        h_vsync_pulse;
    logic        h_eq_pulse;
    logic        h_burst;
    logic        h_active;

    logic        grey_lines;
    logic        red_lines;
    logic        green_lines;
    logic        blue_lines;
    color_t      ramp;

    // line and half-line ends
    assign h_last        = (hcnt == H_TOTAL - 1'b1);
    assign h_half_end    = (hcnt == H_HALF - 1'b1) || h_last;
    assign v_last        = (vcnt == V_TOTAL - 1'b1);
    assign v_field1_last = (vcnt == V_FIELD2_START - 1'b1);

    assign vcnt_next = v_last ? '0 : halfline_t'(vcnt + 1'b1);

    // half-line index relative to the start of its field
    assign field_hl_next = (vcnt_next >= V_FIELD2_START) ?
                           halfline_t'(vcnt_next - V_FIELD2_START) : vcnt_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt           <= '0;
            vcnt           <= '0;
            region         <= EQ_PRE;
            field          <= 1'b0;
            field_line_cnt <= '0;
        end else begin
            hcnt <= h_last ? '0 : hcount_t'(hcnt + 1'b1);

            if (h_half_end) begin
                vcnt   <= vcnt_next;
                region <= region_next;
            end

            // field 2 begins halfway through a line
            if (h_half_end && v_last) begin
                field          <= 1'b0;
                field_line_cnt <= '0;
            end else if (h_half_end && v_field1_last) begin
                field          <= 1'b1;
                field_line_cnt <= '0;
            end else if (h_last) begin
                field_line_cnt <= field_line_cnt + 1'b1;
            end
        end
    end

    // region sequence, same in both fields apart from the active start
    always_comb begin
        region_next = region;
        case (region)
            EQ_PRE: begin
                if (field_hl_next == V_VSYNC_FIRST)
                    region_next = VSYNC;
            end
            VSYNC: begin
                if (field_hl_next == V_EQ_POST_FIRST)
                    region_next = EQ_POST;
            end
            EQ_POST: begin
                if (field_hl_next == V_BLANK_FIRST)
                    region_next = BLANK;
            end
            BLANK: begin
                if (field_hl_next == '0)
                    region_next = EQ_PRE;
                else if (vcnt_next == V_ACT1_FIRST || vcnt_next == V_ACT2_FIRST)
                    region_next = ACTIVE;
            end
            ACTIVE: begin
                if (vcnt_next == V_ACT1_LAST + 1'b1 || vcnt_next == V_ACT2_LAST + 1'b1)
                    region_next = BLANK;
            end
            default: region_next = EQ_PRE;
        endcase
    end

    // pulse shapes along the line
    assign h_hsync_pulse = (hcnt < H_SYNC);

    assign h_vsync_pulse = (hcnt < H_VSYNC_PULSE_LEN) ||
                           (hcnt >= H_HALF && hcnt < H_HALF + H_VSYNC_PULSE_LEN);

    assign h_eq_pulse = (hcnt < H_EQ_PULSE_LEN) ||
                        (hcnt >= H_HALF && hcnt < H_HALF + H_EQ_PULSE_LEN);

    assign h_burst  = (hcnt >= H_BURST_START) && (hcnt < H_BURST_END);
    assign h_active = (hcnt >= H_ACTIVE_START) && (hcnt < H_ACTIVE_END);

    always_comb begin
        case (region)
            VSYNC:           sync_in_n = !h_vsync_pulse;
            EQ_PRE, EQ_POST: sync_in_n = !h_eq_pulse;
            default:         sync_in_n = !h_hsync_pulse;
        endcase
    end

    // burst on every ordinary line, visible or not
    assign color_burst = h_burst && (region == BLANK || region == ACTIVE);
    assign active      = h_active && (region == ACTIVE);

    // colour bands down the frame
    assign frame_line  = {field_line_cnt, field};
    assign grey_lines  = (frame_line < 10'd100);
    assign red_lines   = (frame_line >= 10'd100) && (frame_line < 10'd200);
    assign green_lines = (frame_line >= 10'd200) && (frame_line < 10'd300);
    assign blue_lines  = (frame_line >= 10'd300);

    // brightness steps every 16 clocks
    assign ramp = hcnt[7:4];

    assign r = (grey_lines || red_lines)   ? ramp : '0;
    assign g = (grey_lines || green_lines) ? ramp : '0;
    assign b = (grey_lines || blue_lines)  ? ramp : '0;

    a_hcnt_range: assert property (
        @(posedge clk) disable iff (rst)
        hcnt < H_TOTAL
    );

    a_no_sync_in_picture: assert property (
        @(posedge clk) disable iff (rst)
        active |-> sync_in_n
    );

    // region must stay locked to the half-line count
    a_vsync_placement: assert property (
        @(posedge clk) disable iff (rst)
        (region == VSYNC) |->
            ((vcnt >= V_VSYNC_FIRST && vcnt < V_EQ_POST_FIRST) ||
             (vcnt >= V_FIELD2_START + V_VSYNC_FIRST &&
              vcnt <  V_FIELD2_START + V_EQ_POST_FIRST))
    );

endmodule

`default_nettype wire

/* verilog/video_composite.sv */
`timescale 1ns/10ps
`default_nettype none

module video_composite (
    input  logic               clk,
    input  logic               rst,
    output video_pkg::luma_t   luma,
    output logic               sync_n,
    output video_pkg::chroma_t chroma
);

    import video_pkg::*;

    // raster to modulator
    color_t r;
    color_t g;
    color_t b;
    logic   active;
    logic   color_burst;
    logic   sync_in_n;

    ntsc_raster raster (
        .clk         (clk),
        .rst         (rst),
        .r           (r),
        .g           (g),
        .b           (b),
        .active      (active),
        .color_burst (color_burst),
        .sync_in_n   (sync_in_n)
    );

    // one register stage to the outputs
    video_modulator modulator (
        .clk         (clk),
        .rst         (rst),
        .r           (r),
        .g           (g),
        .b           (b),
        .color_burst (color_burst),
        .active      (active),
        .sync_in_n   (sync_in_n),
        .luma        (luma),
        .sync_n      (sync_n),
        .chroma      (chroma)
    );

endmodule

`default_nettype wire

/* verilog/video_modulator.sv */
`timescale 1ns/10ps
`default_nettype none

module video_modulator (
    input  logic               clk,
    input  logic               rst,
    input  video_pkg::color_t  r,
    input  video_pkg::color_t  g,
    input  video_pkg::color_t  b,
    input  logic               color_burst,
    input  logic               active,
    input  logic               sync_in_n,
    output video_pkg::luma_t   luma,
    output logic               sync_n,
    output video_pkg::chroma_t chroma
);

    import video_pkg::*;

    // hue steps of 22.5 degrees relative to burst
    localparam logic [3:0] HUE_RED     = 4'd5;
    localparam logic [3:0] HUE_YELLOW  = 4'd7;
    localparam logic [3:0] HUE_GREEN   = 4'd11;
    localparam logic [3:0] HUE_CYAN    = 4'd13;
    localparam logic [3:0] HUE_BLUE    = 4'd15;
    localparam logic [3:0] HUE_MAGENTA = 4'd3;

    phase_t            phase;
    logic [7:0]        luma_sum;
    luma_t             luma_next;

    color_t            c_max;
    color_t            c_min;
    color_t            sat;
    logic [2:0]        max_mask;
    logic [3:0]        hue;

    logic [3:0]        sine_idx;
    color_t            ampl;
    logic signed [3:0] sine_val;
    logic signed [8:0] chroma_prod;
    logic signed [8:0] chroma_off;
    logic signed [8:0] chroma_sum;
    chroma_t           chroma_next;

    // one period of sine in 16 steps, peak 7
    function automatic logic signed [3:0] sine_lut(input logic [3:0] idx);
        logic signed [3:0] val;
        case (idx)
            4'd0:    val = 4'sd0;
            4'd1:    val = 4'sd3;
            4'd2:    val = 4'sd5;
            4'd3:    val = 4'sd6;
            4'd4:    val = 4'sd7;
            4'd5:    val = 4'sd6;
            4'd6:    val = 4'sd5;
            4'd7:    val = 4'sd3;
            4'd8:    val = 4'sd0;
            4'd9:    val = -4'sd3;
            4'd10:   val = -4'sd5;
            4'd11:   val = -4'sd6;
            4'd12:   val = -4'sd7;
            4'd13:   val = -4'sd6;
            4'd14:   val = -4'sd5;
            default: val = -4'sd3;
        endcase
        return val;
    endfunction

    // free-running subcarrier
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            phase <= '0;
        else
            phase <= phase + PHASE_STEP;
    end

    // weights roughly 0.3 0.59 0.11 in sixteenths
    assign luma_sum = 8'd5 * r + 8'd9 * g + 8'd2 * b;

    always_comb begin
        if (!sync_in_n)
            luma_next = '0;
        else if (active)
            luma_next = LUMA_BLACK + luma_t'(luma_sum[7:4]);
        else
            luma_next = LUMA_BLACK;
    end

    // spread between components sets saturation
    assign c_max = (r >= g && r >= b) ? r : ((g >= b) ? g : b);
    assign c_min = (r <= g && r <= b) ? r : ((g <= b) ? g : b);
    assign sat   = c_max - c_min;

    // dominant components pick the hue
    assign max_mask = {r == c_max, g == c_max, b == c_max};

    always_comb begin
        case (max_mask)
            3'b100:  hue = HUE_RED;
            3'b110:  hue = HUE_YELLOW;
            3'b010:  hue = HUE_GREEN;
            3'b011:  hue = HUE_CYAN;
            3'b001:  hue = HUE_BLUE;
            3'b101:  hue = HUE_MAGENTA;
            default: hue = 4'd0;
        endcase
    end

    // burst sits opposite the reference phase
    always_comb begin
        if (color_burst) begin
            sine_idx = phase[15:12] + 4'd8;
            ampl     = BURST_AMPL;
        end else begin
            sine_idx = phase[15:12] + hue;
            ampl     = sat;
        end
    end

    assign sine_val    = sine_lut(sine_idx);
    assign chroma_prod = sine_val * $signed({5'b0, ampl});
    assign chroma_off  = chroma_prod >>> 4;
    assign chroma_sum  = $signed({5'b0, CHROMA_MID}) + chroma_off;

    always_comb begin
        if (color_burst || active)
            chroma_next = chroma_sum[3:0];
        else
            chroma_next = CHROMA_MID;
    end

    // all three outputs leave on the same edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            luma   <= LUMA_BLACK;
            sync_n <= 1'b1;
            chroma <= CHROMA_MID;
        end else begin
            luma   <= luma_next;
            sync_n <= sync_in_n;
            chroma <= chroma_next;
        end
    end

    a_chroma_idle: assert property (
        @(posedge clk) disable iff (rst)
        (!color_burst && !active) |=> (chroma == CHROMA_MID)
    );

    a_luma_sync_level: assert property (
        @(posedge clk) disable iff (rst)
        (luma == '0) == !sync_n
    );

endmodule

`default_nettype wire

/* verilog/video_pkg.sv */
package video_pkg;

    // widths that carry a meaning
    typedef logic [10:0] hcount_t;
    typedef logic [10:0] halfline_t;
    typedef logic [9:0]  frame_line_t;
    typedef logic [3:0]  color_t;
    typedef logic [4:0]  luma_t;
    typedef logic [3:0]  chroma_t;
    typedef logic [15:0] phase_t;

    // vertical regions of one field
    typedef enum logic [2:0] {
        EQ_PRE,
        VSYNC,
        EQ_POST,
        BLANK,
        ACTIVE
    } v_region_t;

    // horizontal timing in clocks
    localparam hcount_t H_SYNC            = 11'd118;
    localparam hcount_t H_BACK_PORCH      = 11'd152;
    localparam hcount_t H_ACTIVE          = 11'd1280;
    localparam hcount_t H_FRONT_PORCH     = 11'd38;
    localparam hcount_t H_TOTAL           = 11'd1588;
    localparam hcount_t H_HALF            = 11'd794;
    localparam hcount_t H_VSYNC_PULSE_LEN = 11'd678;
    localparam hcount_t H_EQ_PULSE_LEN    = 11'd58;
    localparam hcount_t H_BURST_START     = 11'd132;
    localparam hcount_t H_BURST_END       = 11'd196;

    // visible window on a line
    localparam hcount_t H_ACTIVE_START = 11'd270;
    localparam hcount_t H_ACTIVE_END   = 11'd1550;

    // vertical timing in half-lines
    localparam halfline_t V_TOTAL         = 11'd1050;
    localparam halfline_t V_FIELD2_START  = 11'd525;
    localparam halfline_t V_VSYNC_FIRST   = 11'd6;
    localparam halfline_t V_EQ_POST_FIRST = 11'd12;
    localparam halfline_t V_BLANK_FIRST   = 11'd18;

    // visible half-lines, both fields
    localparam halfline_t V_ACT1_FIRST = 11'd42;
    localparam halfline_t V_ACT1_LAST  = 11'd521;
    localparam halfline_t V_ACT2_FIRST = 11'd568;
    localparam halfline_t V_ACT2_LAST  = 11'd1047;

    // output levels
    localparam luma_t   LUMA_BLACK = 5'd8;
    localparam chroma_t CHROMA_MID = 4'd8;
    localparam color_t  BURST_AMPL = 4'd8;

    // 3.579545 MHz subcarrier from a 25 MHz clock, 2^16 per cycle
    localparam phase_t PHASE_STEP = 16'd9384;

endpackage

/* video_composite.f */
verilog/video_pkg.sv
verilog/ntsc_raster.sv
verilog/video_modulator.sv
verilog/video_composite.sv
tb/tb_video_composite.sv
